//--- dekatronMachine.f
+incdir+include
verilog/dekatronPkg.sv
verilog/bcdCounter.sv
verilog/insnDecoder.sv
verilog/executeUnit.sv
verilog/consoleUnit.sv
verilog/dekatronMachine.sv
testbench/dekatronMachineTb.sv

//--- runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module dekatronMachineTb \
    -f dekatronMachine.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation finished without errors" ||
{ echo "Simulation reported errors or did not build"; exit 1; }

//--- testbench/dekatronMachineTb.sv
`default_nettype none

`include "dekatron_consts.svh"

module dekatronMachineTb
    import dekatronPkg::*;
();

    logic                               Clk;
    logic                               reset;
    logic                               progWrite;
    logic [`IP_DIGITS*`DIGIT_WIDTH-1:0]   progAddr;
    logic [`CHAR_WIDTH-1:0]             progData;
    logic                               run;
    logic                               halt;
    logic                               step;
    logic [`CHAR_WIDTH-1:0]             stdout;
    logic                               Cout;
    logic [`CHAR_WIDTH-1:0]             stdin;
    logic                               CinReq;
    logic                               CioAcq;
    machineStateT                       state;
    logic [`IP_DIGITS*`DIGIT_WIDTH-1:0]   ipAddress;
    logic [`AP_DIGITS*`DIGIT_WIDTH-1:0]   apAddress;
    logic [`LOOP_DIGITS*`DIGIT_WIDTH-1:0] loopCount;

    int outQ[$];          // Bytes taken by the console responder
    int errorCount = 0;
    int testCount = 0;
    int runIndex = 0;
    int budget = 100;     // Cycle limit, grows with every program
    int cycleCount = 0;
    int maxLoop = 0;      // Deepest loopCount seen in a scan, in BCD

    dekatronMachine i_dekatronMachine (
        .Clk(Clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .run(run), .halt(halt), .step(step),
        .stdout(stdout), .Cout(Cout), .stdin(stdin), .CinReq(CinReq), .CioAcq(CioAcq),
        .state(state), .ipAddress(ipAddress), .apAddress(apAddress), .loopCount(loopCount)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    task automatic protocolError(input string msg);
        errorCount++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    assert property (@(posedge Clk) disable iff (reset) (Cout && !CioAcq) |=> $stable(stdout))
        else protocolError("stdout changed while waiting for an acknowledge");
    assert property (@(posedge Clk) !(Cout && CinReq))
        else protocolError("Cout and CinReq were high together");
    assert property (@(posedge Clk) (reset || state == ST_HALTED) |-> (!Cout && !CinReq))
        else protocolError("console request raised in reset or while halted");

    // Restarted by each run pulse
    always @(negedge Clk) begin
        if (run) begin
            maxLoop = 0;
        end else if ((state == ST_SCAN_FWD || state == ST_SCAN_BACK)
                     && int'(loopCount) > maxLoop) begin
            maxLoop = int'(loopCount);
        end
    end

    task automatic expectValue(input string what, input int got, input int expected);
        assert (got == expected) else begin
            errorCount++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic int toBcd(input int n);
        return (n / 10) * 16 + n % 10;
    endfunction

    // Brainfuck on decimal cells, returns the number of characters passed
    function automatic int modelRun(input string prog, input int inByte, ref int outs[$],
                                    ref int maxDepth);
        int cells [100];
        int ip;
        int ap;
        int depth;
        int events;
        foreach (cells[k]) begin
            cells[k] = 0;
        end
        ip = 0;
        ap = 0;
        events = 0;
        maxDepth = 0;
        while (ip < prog.len()) begin
            events++;
            case (prog[ip])
                "+": cells[ap] = (cells[ap] + 1) % 1000;
                "-": cells[ap] = (cells[ap] + 999) % 1000; // 000 wraps to 999
                ">": ap = (ap + 1) % 100;
                "<": ap = (ap + 99) % 100;
                ".": outs.push_back(cells[ap] % 256);
                ",": cells[ap] = inByte;
                "[": begin
                    depth = (cells[ap] == 0) ? 1 : 0;
                    while (depth > 0) begin
                        ip++;
                        events++;
                        depth += (prog[ip] == "[") ? 1 : (prog[ip] == "]") ? -1 : 0;
                        if (depth - 1 > maxDepth) begin
                            maxDepth = depth - 1;
                        end
                    end
                end
                "]": begin
                    depth = (cells[ap] != 0) ? 1 : 0;
                    while (depth > 0) begin
                        ip--;
                        events++;
                        depth += (prog[ip] == "]") ? 1 : (prog[ip] == "[") ? -1 : 0;
                        if (depth - 1 > maxDepth) begin
                            maxDepth = depth - 1;
                        end
                    end
                end
                default: ;
            endcase
            ip++;
        end
        return events;
    endfunction

    // Each run works on cells no earlier run touched
    function automatic string freshProgram(input string body);
        string prefix;
        prefix = "";
        for (int i = 0; i < 3 * runIndex; i++) begin
            prefix = {prefix, ">"};
        end
        runIndex++;
        return {prefix, body};
    endfunction

    task automatic restartMachine();
        reset = 1'b1; // Brings IP and AP back to zero, cells keep their values
        repeat (2) @(posedge Clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic loadProgram(input string prog);
        for (int i = 0; i <= prog.len(); i++) begin
            progWrite = 1'b1;
            progAddr = {4'(i / 10), 4'(i % 10)};
            progData = (i < prog.len()) ? prog[i] : 8'h00; // Terminator last
            @(posedge Clk);
            #1;
        end
        progWrite = 1'b0;
    endtask

    task automatic pulseControl(input logic doRun, input logic doStep, input logic doHalt);
        run = doRun;
        step = doStep;
        halt = doHalt;
        @(posedge Clk);
        #1;
        run = 1'b0;
        step = 1'b0;
        halt = 1'b0;
    endtask

    task automatic waitHalted();
        while (state != ST_HALTED) begin
            @(posedge Clk);
            #1;
        end
        @(posedge Clk); // Dirty cell goes back to memory
        #1;
    endtask

    task automatic checkProgram(input string body, input int inByte);
        string prog;
        int expOut[$];
        int expDepth;
        int events;
        prog = freshProgram(body);
        events = modelRun(prog, inByte, expOut, expDepth);
        budget += 12 * events + 3 * prog.len() + 60; // Acknowledge delay up to 7
        outQ.delete();
        stdin = 8'(inByte);
        restartMachine();
        loadProgram(prog);
        pulseControl(1'b1, 1'b0, 1'b0);
        waitHalted();
        expectValue({"output count of ", body}, outQ.size(), expOut.size());
        foreach (expOut[k]) begin
            if (k < outQ.size()) begin
                expectValue({"output byte of ", body}, outQ[k], expOut[k]);
            end
        end
        expectValue({"scan depth of ", body}, maxLoop, toBcd(expDepth));
    endtask

    task automatic stepThrough(input string body);
        string prog;
        int offset;
        offset = 3 * runIndex;
        prog = freshProgram(body);
        budget += 12 * prog.len() + 60;
        restartMachine();
        loadProgram(prog);
        for (int i = 1; i <= prog.len(); i++) begin
            pulseControl(1'b0, 1'b1, 1'b0);
            waitHalted();
            expectValue("ipAddress after step", int'(ipAddress), toBcd(i));
        end
        expectValue("apAddress after steps", int'(apAddress), toBcd(offset));
    endtask

    // The loop is the last two characters of the body
    task automatic haltRunning(input string body);
        string prog;
        prog = freshProgram(body);
        budget += 3 * prog.len() + 120;
        restartMachine();
        loadProgram(prog);
        pulseControl(1'b1, 1'b0, 1'b0);
        while (state != ST_SCAN_BACK) begin // First jump back into the loop
            @(posedge Clk);
            #1;
        end
        repeat (8) @(posedge Clk);
        #1;
        expectValue("running before halt", int'(state != ST_HALTED), 1);
        pulseControl(1'b0, 1'b0, 1'b1);
        waitHalted();
        expectValue("halted inside the loop",
                    int'(int'(ipAddress) >= toBcd(prog.len() - 2)
                         && int'(ipAddress) < toBcd(prog.len())), 1);
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        $display("test %0d %s: %s", testCount, name, (errorCount == errsBefore) ? "ok" : "FAILED");
    endtask

    initial begin : responder
        int delay;
        CioAcq = 1'b0;
        forever begin
            @(posedge Clk);
            #1;
            if (Cout || CinReq) begin
                delay = int'($urandom % 8);
                repeat (delay) begin
                    @(posedge Clk);
                    #1;
                end
                if (Cout) begin
                    outQ.push_back(int'(stdout)); // Byte is stable until acknowledged
                end
                CioAcq = Cout || CinReq;
                @(posedge Clk);
                #1;
                CioAcq = 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (cycleCount <= budget) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: no result after %0d cycles", budget);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int errsBefore;
        int v;
        void'($urandom(48500));
        reset = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        run = 1'b0;
        halt = 1'b0;
        step = 1'b0;
        stdin = '0;
        repeat (16) @(posedge Clk);
        #1;
        reset = 1'b0;

        errsBefore = errorCount;
        expectValue("state after reset", int'(state == ST_HALTED), 1);
        expectValue("Cout after reset", int'(Cout), 0);
        expectValue("CinReq after reset", int'(CinReq), 0);
        expectValue("ipAddress after reset", int'(ipAddress), 0);
        expectValue("apAddress after reset", int'(apAddress), 0);
        expectValue("loopCount after reset", int'(loopCount), 0);
        reportTest("reset", errsBefore);

        errsBefore = errorCount;
        checkProgram("+++.", 0);
        checkProgram("-.", 0);
        reportTest("decimal arithmetic", errsBefore);

        errsBefore = errorCount;
        checkProgram(">++ x <+>.", 0);
        reportTest("pointers and comments", errsBefore);

        errsBefore = errorCount;
        checkProgram("++++[>+++<-]>.", 0);
        checkProgram("[+++].", 0);
        checkProgram("[[-]+].", 0); // Nested skip
        reportTest("loops", errsBefore);

        errsBefore = errorCount;
        v = int'($urandom % 256);
        checkProgram(",+.", v);
        checkProgram("+.+.+.+.", 0); // More acknowledge delays on output
        reportTest("input and back-pressure", errsBefore);

        errsBefore = errorCount;
        stepThrough("+>+<");
        haltRunning("+[]");
        reportTest("step and halt", errsBefore);

        $display("%0d tests run, %0d checks failed", testCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dekatronMachine.sv
`default_nettype none

`include "dekatron_consts.svh"

module dekatronMachine
    import dekatronPkg::*;
(
    input  logic                               Clk,
    input  logic                               reset,
    input  logic                               progWrite,
    input  logic [`IP_DIGITS*`DIGIT_WIDTH-1:0]   progAddr,
    input  logic [`CHAR_WIDTH-1:0]             progData,
    input  logic                               run,
    input  logic                               halt,
    input  logic                               step,
    output logic [`CHAR_WIDTH-1:0]             stdout,
    output logic                               Cout,
    input  logic [`CHAR_WIDTH-1:0]             stdin,
    output logic                               CinReq,
    input  logic                               CioAcq,
    output machineStateT                       state,
    output logic [`IP_DIGITS*`DIGIT_WIDTH-1:0]   ipAddress,
    output logic [`AP_DIGITS*`DIGIT_WIDTH-1:0]   apAddress,
    output logic [`LOOP_DIGITS*`DIGIT_WIDTH-1:0] loopCount
);

    localparam int CELL_W = `DATA_DIGITS * `DIGIT_WIDTH;
    localparam int PROG_IDX_W = $clog2(`PROG_DEPTH);

    logic [`CHAR_WIDTH-1:0] progMem [`PROG_DEPTH];
    logic [`CHAR_WIDTH-1:0] character;
    opcodeT                 opcode;
    logic                   outReq;
    logic                   inReq;
    logic                   ioDone;
    logic [CELL_W-1:0]      cellValue;
    logic [CELL_W-1:0]      inValue;

    // Loading only while stopped
    always_ff @(posedge Clk) begin
        if (progWrite && state == ST_HALTED) begin
            progMem[PROG_IDX_W'(bcdToIndex(progAddr))] <= progData;
        end
    end

    assign character = progMem[PROG_IDX_W'(bcdToIndex(ipAddress))]; // Async read at IP

    insnDecoder decoder (
        .character(character),
        .opcode(opcode)
    );

    executeUnit execute (
        .Clk(Clk), .reset(reset), .run(run), .halt(halt), .step(step),
        .opcode(opcode), .ioDone(ioDone), .inValue(inValue),
        .outReq(outReq), .inReq(inReq), .cellValue(cellValue),
        .ipAddress(ipAddress), .apAddress(apAddress), .loopCount(loopCount),
        .state(state)
    );

    consoleUnit console (
        .Clk(Clk), .reset(reset), .outReq(outReq), .inReq(inReq),
        .cellValue(cellValue), .CioAcq(CioAcq), .stdin(stdin),
        .stdout(stdout), .Cout(Cout), .CinReq(CinReq),
        .ioDone(ioDone), .inValue(inValue)
    );

endmodule

`default_nettype wire

//--- verilog/consoleUnit.sv
`default_nettype none

`include "dekatron_consts.svh"

module consoleUnit (
    input  logic                               Clk,
    input  logic                               reset,
    input  logic                               outReq,
    input  logic                               inReq,
    input  logic [`DATA_DIGITS*`DIGIT_WIDTH-1:0] cellValue,
    input  logic                               CioAcq,
    input  logic [`CHAR_WIDTH-1:0]             stdin,
    output logic [`CHAR_WIDTH-1:0]             stdout,
    output logic                               Cout,
    output logic                               CinReq,
    output logic                               ioDone,
    output logic [`DATA_DIGITS*`DIGIT_WIDTH-1:0] inValue
);

    localparam int DW = `DIGIT_WIDTH;

    logic [9:0] cellBinary;
    logic       idle;

    // Byte 0..255 to three BCD digits by shift and add 3
    function automatic logic [3*DW-1:0] byteToBcd(input logic [`CHAR_WIDTH-1:0] b);
        logic [3*DW+`CHAR_WIDTH-1:0] shift;
        shift = {{(3*DW){1'b0}}, b};
        for (int i = 0; i < `CHAR_WIDTH; i++) begin
            for (int d = 0; d < 3; d++) begin
                if (shift[`CHAR_WIDTH+d*DW +: DW] >= 4'd5) begin
                    shift[`CHAR_WIDTH+d*DW +: DW] = shift[`CHAR_WIDTH+d*DW +: DW] + 4'd3;
                end
            end
            shift = shift << 1;
        end
        return shift[3*DW+`CHAR_WIDTH-1:`CHAR_WIDTH];
    endfunction

    // Hundreds, tens, ones; stdout keeps it modulo 256
    assign cellBinary = 10'(cellValue[3*DW-1:2*DW]) * 10'd100
                      + 10'(cellValue[2*DW-1:DW]) * 10'd10
                      + 10'(cellValue[DW-1:0]);

    assign idle = !Cout && !CinReq && !ioDone;

    always_ff @(posedge Clk) begin
        if (reset) begin
            Cout <= 1'b0;
            CinReq <= 1'b0;
            ioDone <= 1'b0;
        end else begin
            ioDone <= 1'b0;
            if (Cout) begin
                Cout <= outReq && !CioAcq; // Request gone means aborted
                ioDone <= outReq && CioAcq;
            end else if (CinReq) begin
                CinReq <= inReq && !CioAcq;
                ioDone <= inReq && CioAcq;
            end else if (idle) begin
                Cout <= outReq;
                CinReq <= inReq && !outReq;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (idle && outReq) begin
            stdout <= cellBinary[`CHAR_WIDTH-1:0]; // Held until acknowledged
        end
        if (CinReq && CioAcq) begin
            inValue <= byteToBcd(stdin);
        end
    end

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
`default_nettype none

`include "dekatron_consts.svh"

module executeUnit
    import dekatronPkg::*;
(
    input  logic                               Clk,
    input  logic                               reset,
    input  logic                               run,
    input  logic                               halt,
    input  logic                               step,
    input  opcodeT                             opcode,
    input  logic                               ioDone,
    input  logic [`DATA_DIGITS*`DIGIT_WIDTH-1:0] inValue,
    output logic                               outReq,
    output logic                               inReq,
    output logic [`DATA_DIGITS*`DIGIT_WIDTH-1:0] cellValue,
    output logic [`IP_DIGITS*`DIGIT_WIDTH-1:0]   ipAddress,
    output logic [`AP_DIGITS*`DIGIT_WIDTH-1:0]   apAddress,
    output logic [`LOOP_DIGITS*`DIGIT_WIDTH-1:0] loopCount,
    output machineStateT                       state
);

    localparam int CELL_W = `DATA_DIGITS * `DIGIT_WIDTH;
    localparam int DATA_IDX_W = $clog2(`DATA_DEPTH);

    machineStateT stateReg;
    machineStateT stateNext;
    machineStateT doneState; // Where a finished instruction goes

    logic stepMode;
    logic ioInput;
    logic cellDirty;
    logic memWrite;

    logic ipUp, ipDown;
    logic apUp, apDown;
    logic loopUp, loopDown, loopClear;
    logic cellUp, cellDown, cellLoad;
    logic [CELL_W-1:0] cellLoadValue;
    logic cellIsZero;
    logic loopIsZero;

    logic [CELL_W-1:0] dataMem [`DATA_DEPTH];
    logic [DATA_IDX_W-1:0] apIndex;

    assign apIndex = DATA_IDX_W'(bcdToIndex(apAddress));
    assign doneState = stepMode ? ST_HALTED : ST_FETCH;

    always_comb begin
        stateNext = stateReg;
        ipUp = 1'b0;
        ipDown = 1'b0;
        apUp = 1'b0;
        apDown = 1'b0;
        loopUp = 1'b0;
        loopDown = 1'b0;
        loopClear = 1'b0;
        cellUp = 1'b0;
        cellDown = 1'b0;
        cellLoad = 1'b0;
        cellLoadValue = dataMem[apIndex];
        if (halt && stateReg != ST_HALTED) begin
            stateNext = ST_HALTED; // Freeze where we are
        end else begin
            case (stateReg)
                ST_HALTED: begin
                    if (run || step) begin
                        stateNext = ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    cellLoad = !cellDirty; // Dirty cell is already current
                    stateNext = ST_EXEC;
                end
                ST_EXEC: begin
                    case (opcode)
                        OP_INC: begin
                            cellUp = 1'b1;
                            ipUp = 1'b1;
                            stateNext = doneState;
                        end
                        OP_DEC: begin
                            cellDown = 1'b1;
                            ipUp = 1'b1;
                            stateNext = doneState;
                        end
                        OP_RIGHT: begin
                            apUp = 1'b1;
                            ipUp = 1'b1;
                            stateNext = doneState;
                        end
                        OP_LEFT: begin
                            apDown = 1'b1;
                            ipUp = 1'b1;
                            stateNext = doneState;
                        end
                        OP_OPEN: begin
                            ipUp = 1'b1;
                            if (cellIsZero) begin
                                loopClear = 1'b1;
                                stateNext = ST_SCAN_FWD;
                            end else begin
                                stateNext = doneState;
                            end
                        end
                        OP_CLOSE: begin
                            if (!cellIsZero) begin
                                ipDown = 1'b1;
                                loopClear = 1'b1;
                                stateNext = ST_SCAN_BACK;
                            end else begin
                                ipUp = 1'b1;
                                stateNext = doneState;
                            end
                        end
                        OP_OUT, OP_IN: begin
                            stateNext = ST_WAIT_IO;
                        end
                        OP_HALT: begin
                            stateNext = ST_HALTED; // IP stays on the terminator
                        end
                        default: begin
                            ipUp = 1'b1;
                            stateNext = doneState;
                        end
                    endcase
                end
                ST_SCAN_FWD: begin
                    ipUp = 1'b1;
                    if (opcode == OP_OPEN) begin
                        loopUp = 1'b1;
                    end else if (opcode == OP_CLOSE) begin
                        if (loopIsZero) begin
                            stateNext = doneState; // Land past the match
                        end else begin
                            loopDown = 1'b1;
                        end
                    end else if (opcode == OP_HALT) begin
                        ipUp = 1'b0;
                        stateNext = ST_HALTED; // Unmatched bracket
                    end
                end
                ST_SCAN_BACK: begin
                    if (opcode == OP_CLOSE) begin
                        loopUp = 1'b1;
                        ipDown = 1'b1;
                    end else if (opcode == OP_OPEN && loopIsZero) begin
                        ipUp = 1'b1;
                        stateNext = doneState;
                    end else if (opcode == OP_OPEN) begin
                        loopDown = 1'b1;
                        ipDown = 1'b1;
                    end else if (opcode == OP_HALT) begin
                        stateNext = ST_HALTED;
                    end else begin
                        ipDown = 1'b1;
                    end
                end
                ST_WAIT_IO: begin
                    if (ioDone) begin
                        ipUp = 1'b1;
                        cellLoad = ioInput;
                        cellLoadValue = inValue;
                        stateNext = doneState;
                    end
                end
                default: begin
                    stateNext = ST_HALTED;
                end
            endcase
        end
    end

    // Modified cell goes back on the next fetch or when halted
    assign memWrite = cellDirty && (stateReg == ST_FETCH || stateReg == ST_HALTED);

    always_ff @(posedge Clk) begin
        if (reset) begin
            stateReg <= ST_HALTED;
            stepMode <= 1'b0;
            ioInput <= 1'b0;
            cellDirty <= 1'b0;
        end else begin
            stateReg <= stateNext;
            if (stateReg == ST_HALTED && (run || step)) begin
                stepMode <= !run;
            end
            if (stateReg == ST_EXEC) begin
                ioInput <= (opcode == OP_IN);
            end
            if (cellUp || cellDown || (cellLoad && stateReg == ST_WAIT_IO)) begin
                cellDirty <= 1'b1;
            end else if (memWrite) begin
                cellDirty <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (memWrite) begin
            dataMem[apIndex] <= cellValue;
        end
    end

    bcdCounter #(.DIGITS(`IP_DIGITS)) ipCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .load(1'b0), .loadValue('0),
        .up(ipUp), .down(ipDown), .value(ipAddress), .isZero()
    );

    bcdCounter #(.DIGITS(`AP_DIGITS)) apCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .load(1'b0), .loadValue('0),
        .up(apUp), .down(apDown), .value(apAddress), .isZero()
    );

    bcdCounter #(.DIGITS(`LOOP_DIGITS)) loopCounter (
        .Clk(Clk), .reset(reset), .clear(loopClear), .load(1'b0), .loadValue('0),
        .up(loopUp), .down(loopDown), .value(loopCount), .isZero(loopIsZero)
    );

    // Working register for the cell under AP
    bcdCounter #(.DIGITS(`DATA_DIGITS)) cellCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .load(cellLoad), .loadValue(cellLoadValue),
        .up(cellUp), .down(cellDown), .value(cellValue), .isZero(cellIsZero)
    );

    assign outReq = (stateReg == ST_WAIT_IO) && !ioInput;
    assign inReq = (stateReg == ST_WAIT_IO) && ioInput;
    assign state = stateReg;

endmodule

`default_nettype wire

//--- verilog/insnDecoder.sv
`default_nettype none

`include "dekatron_consts.svh"

module insnDecoder
    import dekatronPkg::*;
(
    input  logic [`CHAR_WIDTH-1:0] character,
    output opcodeT                 opcode
);

    // Anything not a command is a comment
    always_comb begin
        case (character)
            8'h2B: begin
                opcode = OP_INC; // +
            end
            8'h2D: begin
                opcode = OP_DEC; // -
            end
            8'h3E: begin
                opcode = OP_RIGHT; // >
            end
            8'h3C: begin
                opcode = OP_LEFT; // <
            end
            8'h5B: begin
                opcode = OP_OPEN; // [
            end
            8'h5D: begin
                opcode = OP_CLOSE; // ]
            end
            8'h2E: begin
                opcode = OP_OUT; // .
            end
            8'h2C: begin
                opcode = OP_IN; // ,
            end
            8'h00: begin
                opcode = OP_HALT; // Terminator
            end
            default: begin
                opcode = OP_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/bcdCounter.sv
`default_nettype none

`include "dekatron_consts.svh"

module bcdCounter #(
    parameter int DIGITS = 2
) (
    input  logic                          Clk,
    input  logic                          reset,
    input  logic                          clear,
    input  logic                          load,
    input  logic [DIGITS*`DIGIT_WIDTH-1:0] loadValue,
    input  logic                          up,
    input  logic                          down,
    output logic [DIGITS*`DIGIT_WIDTH-1:0] value,
    output logic                          isZero
);

    localparam int W = DIGITS * `DIGIT_WIDTH;

    logic [W-1:0] incValue;
    logic [W-1:0] decValue;

    // Ripple carry through the tubes, 9 rolls over to 0
    always_comb begin
        logic carry;
        logic borrow;
        logic [`DIGIT_WIDTH-1:0] digit;
        carry = 1'b1;
        borrow = 1'b1;
        incValue = value;
        decValue = value;
        for (int i = 0; i < DIGITS; i++) begin
            digit = value[i*`DIGIT_WIDTH +: `DIGIT_WIDTH];
            if (carry) begin
                if (digit >= 4'd9) begin
                    incValue[i*`DIGIT_WIDTH +: `DIGIT_WIDTH] = 4'd0; // Carry on
                end else begin
                    incValue[i*`DIGIT_WIDTH +: `DIGIT_WIDTH] = digit + 4'd1;
                    carry = 1'b0;
                end
            end
            if (borrow) begin
                if (digit == 4'd0) begin
                    decValue[i*`DIGIT_WIDTH +: `DIGIT_WIDTH] = 4'd9; // Borrow on
                end else begin
                    decValue[i*`DIGIT_WIDTH +: `DIGIT_WIDTH] = digit - 4'd1;
                    borrow = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset || clear) begin
            value <= '0;
        end else if (load) begin
            value <= loadValue;
        end else if (up) begin
            value <= incValue;
        end else if (down) begin
            value <= decValue;
        end
    end

    assign isZero = (value == '0);

endmodule

`default_nettype wire

//--- verilog/dekatronPkg.sv
`default_nettype none

`include "dekatron_consts.svh"

package dekatronPkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_INC,   // +
        OP_DEC,   // -
        OP_RIGHT, // >
        OP_LEFT,  // <
        OP_OPEN,  // [
        OP_CLOSE, // ]
        OP_OUT,   // .
        OP_IN,    // ,
        OP_HALT   // End of program byte
    } opcodeT;

    typedef enum logic [2:0] {
        ST_HALTED,
        ST_FETCH,
        ST_EXEC,
        ST_SCAN_FWD,
        ST_SCAN_BACK,
        ST_WAIT_IO
    } machineStateT;

    // Two BCD digits to a binary memory index
    function automatic logic [7:0] bcdToIndex(input logic [2*`DIGIT_WIDTH-1:0] bcd);
        return 8'(bcd[2*`DIGIT_WIDTH-1:`DIGIT_WIDTH]) * 8'd10 + 8'(bcd[`DIGIT_WIDTH-1:0]);
    endfunction

endpackage

`default_nettype wire

//--- include/dekatron_consts.svh
`ifndef DEKATRON_CONSTS_SVH
`define DEKATRON_CONSTS_SVH

// One dekatron tube per BCD digit
`define DIGIT_WIDTH 4

`define IP_DIGITS   2 // Instruction pointer 00..99
`define AP_DIGITS   2 // Address pointer 00..99
`define DATA_DIGITS 3 // Cell value 000..999
`define LOOP_DIGITS 2 // Bracket depth while scanning

`define PROG_DEPTH  100
`define DATA_DEPTH  100

// Console byte
`define CHAR_WIDTH  8

`endif
